// ==== Makefile ====
# Verilator build and run for the array heap testbench
VERILATOR ?= verilator
TOP       ?= heapTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Compile, then run; the run exits nonzero on $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== project.f ====
source/heapPkg.sv
source/elementStore.sv
source/arrayDirectory.sv
source/heapController.sv
source/heapTop.sv
tb/heapClockGen.sv
tb/heapChk.sv
tb/heapTb.sv

// ==== source/arrayDirectory.sv ====
/*
  Bookkeeping for every array: issued count, allocated flags, sizes and
  a LIFO of freed numbers. Lookups are combinational, updates on strobes.
*/
`timescale 1ns/1ps

module arrayDirectory
  import heapPkg::*;
(
  input  logic     clock,
  input  logic     resetN,
  input  arrayNumT dirArray,
  output logic     issued,
  output logic     live,
  output sizeT     curSize,
  output arrayNumT allocNum,
  output logic     allocOk,
  input  logic     sizeWe,
  input  sizeT     newSize,
  input  logic     allocDo,
  input  logic     freeDo,
  input  logic     clearDo
);

  typedef logic [arrayBits:0] countT;                  // 0 to arrayCount

  countT                 issuedCount;                  // Fresh numbers handed out
  countT                 freeTop;                      // Entries on the free stack
  logic [arrayCount-1:0] allocated;
  sizeT                  sizes [arrayCount];
  arrayNumT              freeStack [arrayCount];
  logic                  stackNotEmpty;

  // ------------------------------
  // Lookups
  // ------------------------------
  assign stackNotEmpty = (freeTop != '0);
  assign issued        = countT'(dirArray) < issuedCount;
  assign live          = allocated[dirArray];
  assign curSize       = sizes[dirArray];
  assign allocOk       = stackNotEmpty || (issuedCount < countT'(arrayCount));

  // Reuse the most recently freed array first
  assign allocNum = stackNotEmpty ? freeStack[arrayNumT'(freeTop - countT'(1))]
                                  : arrayNumT'(issuedCount);

  // ------------------------------
  // Updates
  // ------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      issuedCount <= '0;
      freeTop     <= '0;
      allocated   <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (clearDo) begin                        // Same as reset
      issuedCount <= '0;
      freeTop     <= '0;
      allocated   <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (allocDo) begin
        if (stackNotEmpty) freeTop <= freeTop - countT'(1);   // Pop a freed one
        else issuedCount <= issuedCount + countT'(1);         // Or issue a fresh one
        allocated[allocNum] <= 1'b1;
        sizes[allocNum]     <= '0;                     // New arrays start empty
      end
      if (freeDo) begin
        freeTop             <= freeTop + countT'(1);
        allocated[dirArray] <= 1'b0;                   // The freed array itself
      end
      if (sizeWe) sizes[dirArray] <= newSize;
    end
  end

  // Freed number goes onto the stack top
  always_ff @(posedge clock) begin
    if (freeDo) freeStack[arrayNumT'(freeTop)] <= dirArray;
  end

endmodule

// ==== source/elementStore.sv ====
/*
  Element memory, one word per array and index.
  Registered read, single write port, no reset on contents.
*/
`timescale 1ns/1ps

module elementStore
  import heapPkg::*;
(
  input  logic                           clock,
  input  logic [arrayBits+indexBits-1:0] rdAddr,   // {array, index}
  output dataT                           rdData,
  input  logic                           we,
  input  logic [arrayBits+indexBits-1:0] wrAddr,
  input  dataT                           wrData
);

  // ------------------------------
  // Storage
  // ------------------------------
  dataT mem [arrayCount*arrayLength];                  // Block RAM sized

  always_ff @(posedge clock) begin
    if (we) mem[wrAddr] <= wrData;
    rdData <= mem[rdAddr];                             // Valid one cycle later
  end

endmodule

// ==== source/heapController.sv ====
/*
  Wishbone slave FSM. Accepts a request, checks it against the directory,
  computes the result in the execute cycle, then acks and writes back.
*/
`timescale 1ns/1ps

module heapController
  import heapPkg::*;
(
  input  logic                           clock,
  input  logic                           resetN,
  input  logic                           cyc,
  input  logic                           stb,
  input  heapReqT                        req,
  output logic                           ack,
  output heapRspT                        rsp,
  output arrayNumT                       dirArray,
  input  logic                           issued,
  input  logic                           live,
  input  sizeT                           curSize,
  input  arrayNumT                       allocNum,
  input  logic                           allocOk,
  output logic                           sizeWe,
  output sizeT                           newSize,
  output logic                           allocDo,
  output logic                           freeDo,
  output logic                           clearDo,
  output logic [arrayBits+indexBits-1:0] rdAddr,
  input  dataT                           rdData,
  output logic                           we,
  output logic [arrayBits+indexBits-1:0] wrAddr,
  output dataT                           wrData
);

  typedef enum logic [1:0] {
    stIdle,                                            // Waiting for cyc and stb
    stExecute,                                         // rdData valid, decide
    stRespond,                                         // ack high, strobes out
    stRecover                                          // Bus settles, stb ignored
  } ctrlStateT;

  ctrlStateT state;
  heapReqT   reqQ;                                     // Held for the whole command
  logic      accept;
  indexT     rdIndex;
  heapErrT   baseErr;                                  // Issued and live checks
  logic      inBounds;
  heapErrT   err;
  dataT      result;
  dataT      aluOut;
  dataT      writeValue;
  indexT     wrIndex;
  sizeT      sizeNext;
  logic      doWrite;
  logic      doSize;
  logic      doAlloc;
  logic      doFree;
  logic      doClear;

  assign accept = (state == stIdle) && cyc && stb;

  // ------------------------------
  // Read side, set up at accept
  // ------------------------------
  assign dirArray = (state == stIdle) ? req.array : reqQ.array;   // Live request until latched
  assign rdIndex  = (req.cmd == cmdPop) ? indexT'(curSize - sizeT'(1)) : req.index;
  assign rdAddr   = {req.array, rdIndex};             // Sampled by the store at accept

  // ------------------------------
  // Execute
  // ------------------------------
  assign baseErr  = !issued ? errNotAllocated : (!live ? errFreed : errNone);
  assign inBounds = sizeT'(reqQ.index) < curSize;

  always_comb begin
    case (reqQ.cmd)
      cmdSubtract: aluOut = rdData - reqQ.data;
      cmdOr:       aluOut = rdData | reqQ.data;
      cmdXor:      aluOut = rdData ^ reqQ.data;
      cmdAnd:      aluOut = rdData & reqQ.data;
      default:     aluOut = rdData + reqQ.data;       // Add and addAfter
    endcase
  end

  // Write and push store the operand, the rest store the ALU result
  assign writeValue = (reqQ.cmd == cmdWrite || reqQ.cmd == cmdPush) ? reqQ.data : aluOut;

  always_comb begin
    err      = errNone;
    result   = '0;
    doWrite  = 1'b0;
    doSize   = 1'b0;
    doAlloc  = 1'b0;
    doFree   = 1'b0;
    doClear  = 1'b0;
    sizeNext = curSize;
    wrIndex  = reqQ.index;
    if (reqQ.cmd == cmdClear) begin
      doClear = 1'b1;
    end else if (reqQ.cmd == cmdAlloc) begin           // No array checks
      if (allocOk) begin
        doAlloc = 1'b1;
        result  = dataT'(allocNum);
      end else begin
        err = errOutOfMemory;
      end
    end else if (baseErr != errNone) begin
      err = baseErr;
    end else begin
      case (reqQ.cmd)
        cmdFree: doFree = 1'b1;
        cmdWrite: begin                                // Any index below arrayLength
          doWrite = 1'b1;
          result  = reqQ.data;
          if (!inBounds) begin                         // Grow to cover the index
            doSize   = 1'b1;
            sizeNext = sizeT'(reqQ.index) + sizeT'(1);
          end
        end
        cmdRead: begin
          if (!inBounds) err = errOutOfBounds;
          else result = rdData;
        end
        cmdSize: result = dataT'(curSize);
        cmdPush: begin
          if (curSize == sizeT'(arrayLength)) begin
            err = errFull;
          end else begin
            doWrite  = 1'b1;
            wrIndex  = indexT'(curSize);               // Slot just past the end
            doSize   = 1'b1;
            sizeNext = curSize + sizeT'(1);
          end
        end
        cmdPop: begin                                  // rdData is element size-1
          if (curSize == '0) begin
            err = errEmpty;
          end else begin
            result   = rdData;
            doSize   = 1'b1;
            sizeNext = curSize - sizeT'(1);
          end
        end
        cmdResize: begin
          if (reqQ.data > dataT'(arrayLength)) begin
            err = errTooLarge;
          end else begin
            doSize   = 1'b1;
            sizeNext = sizeT'(reqQ.data);
          end
        end
        cmdAdd, cmdAddAfter, cmdSubtract, cmdOr, cmdXor, cmdAnd: begin
          if (!inBounds) begin
            err = errOutOfBounds;
          end else begin
            doWrite = 1'b1;
            result  = (reqQ.cmd == cmdAddAfter) ? rdData : aluOut;   // Old or new value
          end
        end
        default: ;                                     // Unused encoding, answers zero
      endcase
    end
  end

  // ------------------------------
  // FSM and write-back strobes
  // ------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= stIdle;
      ack     <= 1'b0;
      we      <= 1'b0;
      sizeWe  <= 1'b0;
      allocDo <= 1'b0;
      freeDo  <= 1'b0;
      clearDo <= 1'b0;
    end else begin
      ack     <= (state == stExecute);                 // Exactly one cycle
      we      <= (state == stExecute) && doWrite;
      sizeWe  <= (state == stExecute) && doSize;
      allocDo <= (state == stExecute) && doAlloc;
      freeDo  <= (state == stExecute) && doFree;
      clearDo <= (state == stExecute) && doClear;
      case (state)
        stIdle:    if (accept) state <= stExecute;
        stExecute: state <= stRespond;
        stRespond: state <= stRecover;
        default:   state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) reqQ <= req;
    if (state == stExecute) begin
      rsp.data <= result;                              // Zero on error
      rsp.err  <= err;
      newSize  <= sizeNext;
      wrAddr   <= {reqQ.array, wrIndex};
      wrData   <= writeValue;
    end
  end

endmodule

// ==== source/heapPkg.sv ====
/*
  Widths, vector types, command and error encodings for the array heap.
  Every RTL block and the testbench import this package.
*/
package heapPkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int arrayBits   = 3;                      // 8 arrays
  localparam int indexBits   = 3;                      // 8 elements per array
  localparam int dataBits    = 16;                     // Element width
  localparam int arrayLength = 1 << indexBits;         // Elements in one array
  localparam int arrayCount  = 1 << arrayBits;         // Arrays in the heap

  typedef logic [arrayBits-1:0] arrayNumT;             // Names an array
  typedef logic [indexBits-1:0] indexT;                // Position within an array
  typedef logic [indexBits:0]   sizeT;                 // 0 to arrayLength inclusive
  typedef logic [dataBits-1:0]  dataT;                 // Element value

  // ------------------------------
  // Commands
  // ------------------------------
  typedef enum logic [3:0] {
    cmdClear,                                          // Forget every array
    cmdAlloc,                                          // Hand out an array
    cmdFree,                                           // Return an array for reuse
    cmdWrite,                                          // Store, may extend size
    cmdRead,                                           // Fetch within size
    cmdSize,                                           // Current size
    cmdPush,                                           // Append at size
    cmdPop,                                            // Remove last
    cmdResize,                                         // Set size from data
    cmdAdd,                                            // Returns new value
    cmdAddAfter,                                       // Returns old value
    cmdSubtract,
    cmdOr,
    cmdXor,
    cmdAnd
  } heapCmdT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                   // Never issued
    errFreed,                                          // Issued, now free
    errOutOfBounds,                                    // Index at or past size
    errFull,                                           // Push onto full array
    errEmpty,                                          // Pop from empty array
    errOutOfMemory,                                    // Alloc with none left
    errTooLarge                                        // Resize past arrayLength
  } heapErrT;

  // ------------------------------
  // Bus payloads
  // ------------------------------
  typedef struct packed {
    heapCmdT  cmd;
    arrayNumT array;
    indexT    index;
    dataT     data;                                    // Operand or new size
  } heapReqT;

  typedef struct packed {
    dataT    data;                                     // Zero on error
    heapErrT err;
  } heapRspT;

endpackage

// ==== source/heapTop.sv ====
/*
  Array heap behind a Wishbone classic slave port.
  One command at a time, ack two cycles after the request is sampled.
*/
`timescale 1ns/1ps

module heapTop
  import heapPkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    cyc,
  input  logic    stb,
  input  heapReqT req,
  output logic    ack,
  output heapRspT rsp
);

  // ------------------------------
  // Directory link
  // ------------------------------
  arrayNumT dirArray;                                  // Array under test
  logic     issued;
  logic     live;
  sizeT     curSize;
  arrayNumT allocNum;                                  // Next array alloc gives out
  logic     allocOk;
  logic     sizeWe;
  sizeT     newSize;
  logic     allocDo;
  logic     freeDo;
  logic     clearDo;

  // ------------------------------
  // Store link
  // ------------------------------
  logic [arrayBits+indexBits-1:0] rdAddr;              // {array, index}
  logic [arrayBits+indexBits-1:0] wrAddr;
  dataT                           rdData;
  dataT                           wrData;
  logic                           we;

  heapController controller (
    .clock, .resetN, .cyc, .stb, .req, .ack, .rsp,
    .dirArray, .issued, .live, .curSize, .allocNum, .allocOk,
    .sizeWe, .newSize, .allocDo, .freeDo, .clearDo,
    .rdAddr, .rdData, .we, .wrAddr, .wrData
  );

  arrayDirectory directory (
    .clock, .resetN, .dirArray, .issued, .live, .curSize, .allocNum, .allocOk,
    .sizeWe, .newSize, .allocDo, .freeDo, .clearDo
  );

  elementStore store (
    .clock, .rdAddr, .rdData, .we, .wrAddr, .wrData
  );

endmodule

// ==== tb/heapChk.sv ====
/*
  Concurrent assertions on the controller's Wishbone handshake.
  Bound into heapController.
*/
`timescale 1ns/1ps

module heapChk (
  input logic clock,
  input logic resetN,
  input logic cyc,
  input logic stb,
  input logic ack
);

  // ------------------------------
  // Ack shape and latency
  // ------------------------------
  ackOneCycle: assert property (@(posedge clock) disable iff (!resetN) ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  // Request sampled on the edge stb is first seen, ack two edges later
  ackLatency: assert property (@(posedge clock) disable iff (!resetN) $rose(stb) |-> ##2 ack)
    else $error("ack did not follow stb by two cycles");

  // Master may drop cyc at the falling edge after ack
  ackInCycle: assert property (@(posedge clock) disable iff (!resetN) ack |-> $past(cyc))
    else $error("ack raised outside a bus cycle");

endmodule

bind heapController heapChk chk (
  .clock  (clock),
  .resetN (resetN),
  .cyc    (cyc),
  .stb    (stb),
  .ack    (ack)
);

// ==== tb/heapClockGen.sv ====
/*
  Testbench clock and reset. 8 ns clock, active-low reset held for two cycles.
*/
`timescale 1ns/1ps

module heapClockGen (
  output logic clock,
  output logic resetN
);

  initial begin
    clock  = 1'b0;
    resetN = 1'b0;                                     // Asserted from time zero
    repeat (2) @(negedge clock);
    resetN = 1'b1;                                     // Released away from posedge
  end

  always #4 clock = ~clock;                            // 8 ns period

endmodule

// ==== tb/heapTb.sv ====
/*
  Testbench for the array heap. Applies a table of commands through the
  Wishbone port and checks every response against the row's expectation.
*/
`timescale 1ns/1ps

module heapTb
  import heapPkg::*;
();

  typedef struct packed {
    heapCmdT  cmd;
    arrayNumT array;
    indexT    index;
    dataT     data;
    dataT     expData;                                 // Expected rsp.data
    heapErrT  expErr;                                  // Expected rsp.err
  } stepT;

  logic    clock;
  logic    resetN;
  logic    cyc;
  logic    stb;
  heapReqT req;
  logic    ack;
  heapRspT rsp;

  stepT steps [$];                                     // Stimulus table
  int   cycleLimit;                                    // Set from the table size
  int   cycles     = 0;

  heapClockGen clockGen (.clock, .resetN);

  heapTop DUT (.clock, .resetN, .cyc, .stb, .req, .ack, .rsp);

  // ------------------------------
  // Failure and compare
  // ------------------------------
  task automatic failRun(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkData(string name, dataT expected, dataT actual, int num);
    if (actual !== expected) begin
      failRun($sformatf("mismatch at %0t: %s expected %h got %h (row %0d)",
                        $time, name, expected, actual, num));
    end
  endtask

  task automatic checkErr(string name, heapErrT expected, heapErrT actual, int num);
    if (actual !== expected) begin
      failRun($sformatf("mismatch at %0t: %s expected %s got %s (row %0d)",
                        $time, name, expected.name(), actual.name(), num));
    end
  endtask

  // ------------------------------
  // Table
  // ------------------------------
  function automatic void addStep(heapCmdT cmd, int array, int index, int data,
                                  int expData, heapErrT expErr);
    stepT s;
    s.cmd     = cmd;
    s.array   = arrayNumT'(array);
    s.index   = indexT'(index);
    s.data    = dataT'(data);
    s.expData = dataT'(expData);
    s.expErr  = expErr;
    steps.push_back(s);
  endfunction

  task automatic buildSteps();
    addStep(cmdClear, 0, 0, 0, 0, errNone);            // Alloc hands out 0 to 7
    for (int k = 0; k < arrayCount; k++) begin
      addStep(cmdAlloc, 0, 0, 0, k, errNone);
    end
    addStep(cmdAlloc, 0, 0, 0, 0, errOutOfMemory);
    addStep(cmdClear, 0, 0, 0, 0, errNone);            // Fresh heap, arrays 0 to 2
    for (int k = 0; k < 3; k++) begin
      addStep(cmdAlloc, 0, 0, 0, k, errNone);
    end
    addStep(cmdRead, 5, 0, 0, 0, errNotAllocated);     // Never issued since clear
    addStep(cmdWrite, 0, 0, 'h1111, 'h1111, errNone);
    addStep(cmdWrite, 0, 2, 'h2222, 'h2222, errNone);  // Grows size to 3
    addStep(cmdSize, 0, 0, 0, 3, errNone);
    addStep(cmdRead, 0, 0, 0, 'h1111, errNone);
    addStep(cmdRead, 0, 2, 0, 'h2222, errNone);
    addStep(cmdRead, 0, 3, 0, 0, errOutOfBounds);
    for (int k = 0; k < arrayLength; k++) begin        // Fill array 1
      addStep(cmdPush, 1, 0, 'h0100 + k, 0, errNone);
    end
    addStep(cmdPush, 1, 0, 'h0BAD, 0, errFull);
    addStep(cmdSize, 1, 0, 0, arrayLength, errNone);
    for (int k = arrayLength - 1; k >= 0; k--) begin   // Last in, first out
      addStep(cmdPop, 1, 0, 0, 'h0100 + k, errNone);
    end
    addStep(cmdPop, 1, 0, 0, 0, errEmpty);
    addStep(cmdWrite, 2, 0, 'h00F0, 'h00F0, errNone);  // Arithmetic on array 2
    addStep(cmdAdd, 2, 0, 'h0010, 'h0100, errNone);
    addStep(cmdAddAfter, 2, 0, 'h0005, 'h0100, errNone);
    addStep(cmdRead, 2, 0, 0, 'h0105, errNone);        // addAfter result lands
    addStep(cmdSubtract, 2, 0, 'h0005, 'h0100, errNone);
    addStep(cmdOr, 2, 0, 'h00FF, 'h01FF, errNone);
    addStep(cmdXor, 2, 0, 'h0F0F, 'h0EF0, errNone);
    addStep(cmdAnd, 2, 0, 'h00FF, 'h00F0, errNone);
    addStep(cmdRead, 2, 0, 0, 'h00F0, errNone);
    addStep(cmdFree, 1, 0, 0, 0, errNone);
    addStep(cmdFree, 2, 0, 0, 0, errNone);
    addStep(cmdFree, 2, 0, 0, 0, errFreed);            // Double free
    addStep(cmdRead, 2, 0, 0, 0, errFreed);
    addStep(cmdSize, 1, 0, 0, 0, errFreed);
    addStep(cmdAlloc, 0, 0, 0, 2, errNone);            // Most recently freed first
    addStep(cmdSize, 2, 0, 0, 0, errNone);
    addStep(cmdAlloc, 0, 0, 0, 1, errNone);
    addStep(cmdSize, 1, 0, 0, 0, errNone);
    addStep(cmdAlloc, 0, 0, 0, 3, errNone);            // Stack empty, fresh number
    addStep(cmdResize, 3, 0, arrayLength, 0, errNone);
    addStep(cmdSize, 3, 0, 0, arrayLength, errNone);
    addStep(cmdResize, 3, 0, arrayLength + 1, 0, errTooLarge);
    addStep(cmdSize, 3, 0, 0, arrayLength, errNone);   // Unchanged after error
    addStep(cmdResize, 3, 0, 2, 0, errNone);
    addStep(cmdSize, 3, 0, 0, 2, errNone);
  endtask

  // ------------------------------
  // Wishbone master
  // ------------------------------
  task automatic runStep(int num, stepT s);
    @(negedge clock);
    req.cmd   = s.cmd;
    req.array = s.array;
    req.index = s.index;
    req.data  = s.data;
    cyc       = 1'b1;
    stb       = 1'b1;
    @(negedge clock);
    while (ack !== 1'b1) @(negedge clock);             // Timeout bounds this
    checkData("rsp.data", s.expData, rsp.data, num);
    checkErr("rsp.err", s.expErr, rsp.err, num);
    cyc = 1'b0;                                        // Falling edge after ack
    stb = 1'b0;
    @(negedge clock);                                  // Controller recover cycle
  endtask

  initial begin
    cyc = 1'b0;
    stb = 1'b0;
    req = '0;
    buildSteps();
    cycleLimit = steps.size() * 6 + 20;
    @(posedge resetN);
    foreach (steps[i]) begin
      runStep(i, steps[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

  // Whole-run watchdog
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      failRun($sformatf("timeout after %0d cycles, the DUT stopped acknowledging", cycles));
    end
  end

endmodule
